// File: fetch_pkg.sv
`default_nettype none

package fetch_pkg;

	//////////////////////////////////////////////////
	// Address and instruction widths
	//////////////////////////////////////////////////

	// Byte address of an instruction
	typedef logic [11:0] pc_t;

	// One 32-bit instruction word
	typedef logic [31:0] instr_t;

	// Word index into the RAM, PC without its two low bits
	typedef logic [9:0] word_addr_t;

	//////////////////////////////////////////////////
	// Fetch constants
	//////////////////////////////////////////////////

	// Sequential step, one word
	localparam pc_t PC_STEP = 12'd4;

	// PC value after reset and during a reload
	localparam pc_t PC_RESET = '0;

	// Presented while no valid read is in flight
	localparam instr_t INSTR_ZERO = '0;

	// Debug port reaches the first 32 words only
	localparam int DEBUG_ADDR_W = 5;

endpackage

`default_nettype wire

// File: load_pkg.sv
`default_nettype none

package load_pkg;

	//////////////////////////////////////////////////
	// UART framing
	//////////////////////////////////////////////////

	// 8N1 frames, no parity
	localparam int UART_DATA_BITS = 8;

	typedef logic [UART_DATA_BITS-1:0] byte_t;

	// Receiver FSM states
	typedef enum logic [1:0] {
		UART_IDLE,
		UART_START,
		UART_DATA,
		UART_STOP
	} uart_state_t;

	//////////////////////////////////////////////////
	// Program loader
	//////////////////////////////////////////////////

	// Little-endian, least significant byte first on the line
	localparam int BYTES_PER_WORD = 4;

	typedef logic [$clog2(BYTES_PER_WORD)-1:0] byte_idx_t;

endpackage

`default_nettype wire

// File: uart_rx.sv
`timescale 1ns/1ns
`default_nettype none

module uart_rx import load_pkg::*; #(
	parameter int CLKS_PER_BIT = 4
) (
	input  logic  bus,
	input  logic  reset,
	input  logic  rx,
	output byte_t rx_byte,
	output logic  rx_valid
);

	localparam int CNT_W = $clog2(CLKS_PER_BIT + 1);
	localparam int BIT_W = $clog2(UART_DATA_BITS);

	// Last count of a full bit and of half a bit
	localparam logic [CNT_W-1:0] BIT_LAST  = CNT_W'(CLKS_PER_BIT - 1);
	localparam logic [CNT_W-1:0] HALF_LAST = CNT_W'(CLKS_PER_BIT / 2 - 1);
	localparam logic [BIT_W-1:0] LAST_BIT  = BIT_W'(UART_DATA_BITS - 1);

	logic             rx_meta;
	logic             rx_sync;
	uart_state_t      state;
	logic [CNT_W-1:0] clk_cnt;
	logic [BIT_W-1:0] bit_cnt;
	byte_t            shift;
	logic             bit_mid;

	// Two-flop synchronizer, line idles high
	always_ff @(posedge bus) begin
		if (reset) begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
		end else begin
			rx_meta <= rx;
			rx_sync <= rx_meta;
		end
	end

	// Middle of a data or stop bit
	assign bit_mid = (clk_cnt == BIT_LAST);

	//////////////////////////////////////////////////
	// Receiver FSM
	//////////////////////////////////////////////////

	always_ff @(posedge bus) begin
		if (reset) begin
			state    <= UART_IDLE;
			clk_cnt  <= '0;
			bit_cnt  <= '0;
			rx_valid <= 1'b0;
		end else begin
			rx_valid <= 1'b0;
			case (state)
				UART_IDLE: begin
					clk_cnt <= '0;
					bit_cnt <= '0;
					// Falling edge starts a frame
					if (!rx_sync)
						state <= UART_START;
				end
				UART_START: begin
					if (clk_cnt == HALF_LAST) begin
						clk_cnt <= '0;
						// Glitch shorter than half a bit, back to idle
						state   <= rx_sync ? UART_IDLE : UART_DATA;
					end else begin
						clk_cnt <= clk_cnt + 1'b1;
					end
				end
				UART_DATA: begin
					if (bit_mid) begin
						clk_cnt <= '0;
						bit_cnt <= bit_cnt + 1'b1;
						if (bit_cnt == LAST_BIT)
							state <= UART_STOP;
					end else begin
						clk_cnt <= clk_cnt + 1'b1;
					end
				end
				UART_STOP: begin
					if (bit_mid) begin
						clk_cnt  <= '0;
						state    <= UART_IDLE;
						// Bad stop bit drops the byte
						rx_valid <= rx_sync;
					end else begin
						clk_cnt <= clk_cnt + 1'b1;
					end
				end
				default: state <= UART_IDLE;
			endcase
		end
	end

	// Data path, LSB arrives first
	always_ff @(posedge bus) begin
		if (state == UART_DATA && bit_mid)
			shift <= {rx_sync, shift[UART_DATA_BITS-1:1]};
		if (state == UART_STOP && bit_mid)
			rx_byte <= shift;
	end

endmodule

`default_nettype wire

// File: prog_loader.sv
`timescale 1ns/1ns
`default_nettype none

module prog_loader import load_pkg::*, fetch_pkg::*; (
	input  logic       bus,
	input  logic       reset,
	input  logic       prog,
	input  byte_t      rx_byte,
	input  logic       rx_valid,
	output logic       wb_cyc,
	output logic       wb_stb,
	output logic       wb_we,
	output word_addr_t wb_adr,
	output instr_t     wb_dat_w,
	input  logic       wb_ack,
	output logic       load_active
);

	// Bytes held before the last one completes a word
	localparam int BUF_W = (BYTES_PER_WORD - 1) * UART_DATA_BITS;
	localparam byte_idx_t LAST_BYTE = byte_idx_t'(BYTES_PER_WORD - 1);

	logic             prog_q;
	logic             prog_rise;
	logic             byte_take;
	logic             word_done;
	byte_idx_t        byte_cnt;
	logic [BUF_W-1:0] byte_buf;

	assign prog_rise = prog && !prog_q;
	// Bytes only count while programming
	assign byte_take = prog && !prog_rise && rx_valid;
	assign word_done = byte_take && (byte_cnt == LAST_BYTE);

	// Classic single write, strobe follows cycle
	assign wb_stb = wb_cyc;
	assign wb_we  = wb_cyc;

	//////////////////////////////////////////////////
	// Byte count, address and bus cycle
	//////////////////////////////////////////////////

	always_ff @(posedge bus) begin
		if (reset) begin
			prog_q      <= 1'b0;
			byte_cnt    <= '0;
			wb_adr      <= '0;
			wb_cyc      <= 1'b0;
			load_active <= 1'b0;
		end else begin
			prog_q      <= prog;
			// Stays up until a trailing write has finished
			load_active <= prog || wb_cyc;
			if (prog_rise) begin
				// New program always starts at word 0
				byte_cnt <= '0;
				wb_adr   <= '0;
			end else begin
				if (byte_take)
					byte_cnt <= byte_cnt + 1'b1;
				if (wb_cyc && wb_ack)
					wb_adr <= wb_adr + 1'b1;
			end
			// Drop the cycle right after ack
			if (wb_cyc && wb_ack)
				wb_cyc <= 1'b0;
			else if (word_done)
				wb_cyc <= 1'b1;
		end
	end

	// Word assembly, little-endian
	always_ff @(posedge bus) begin
		if (byte_take) begin
			if (byte_cnt == LAST_BYTE)
				wb_dat_w <= {rx_byte, byte_buf};
			else
				byte_buf <= {rx_byte, byte_buf[BUF_W-1:UART_DATA_BITS]};
		end
	end

	// Request held with stable address and data until the RAM acks
	assert property (@(posedge bus) disable iff (reset)
		(wb_stb && !wb_ack) |=> (wb_stb && $stable(wb_adr) && $stable(wb_dat_w)))
	else
		$error("loader dropped or changed a write before ack");

endmodule

`default_nettype wire

// File: iram_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module iram_ctrl import fetch_pkg::*; #(
	parameter int IRAM_WORDS = 1024
) (
	input  logic       bus,
	input  logic       reset,
	input  logic       wb_cyc,
	input  logic       wb_stb,
	input  logic       wb_we,
	input  word_addr_t wb_adr,
	input  instr_t     wb_dat_w,
	output logic       wb_ack,
	input  logic       load_active,
	input  logic       rd_en,
	input  word_addr_t rd_addr,
	output instr_t     rd_data
);

	// Depth is bounded by the word address
	if (IRAM_WORDS > (1 << $bits(word_addr_t))) begin : g_depth_check
		$error("IRAM_WORDS exceeds the word address range");
	end

	instr_t mem [IRAM_WORDS];
	logic   wr_req;
	logic   rd_req;

	// Write on the edge that raises ack
	assign wr_req = load_active && wb_cyc && wb_stb && wb_we && !wb_ack;
	// Fetch owns the port outside a load
	assign rd_req = rd_en && !load_active;

	//////////////////////////////////////////////////
	// Wishbone ack
	//////////////////////////////////////////////////

	// One-cycle pulse, one cycle after stb
	always_ff @(posedge bus) begin
		if (reset)
			wb_ack <= 1'b0;
		else
			wb_ack <= wb_cyc && wb_stb && !wb_ack;
	end

	//////////////////////////////////////////////////
	// Single-port storage
	//////////////////////////////////////////////////

	always_ff @(posedge bus) begin
		if (wr_req)
			mem[wb_adr] <= wb_dat_w;
		else if (rd_req)
			rd_data <= mem[rd_addr];
	end

	// Ack only answers a live request from the loader
	assert property (@(posedge bus) disable iff (reset)
		wb_ack |-> (wb_cyc && wb_stb))
	else
		$error("ack without an active cycle and strobe");

endmodule

`default_nettype wire

// File: fetch_stage.sv
`timescale 1ns/1ns
`default_nettype none

module fetch_stage import fetch_pkg::*; (
	input  logic                    bus,
	input  logic                    reset,
	input  logic                    pc_en,
	input  logic                    debug,
	input  logic [DEBUG_ADDR_W-1:0] debug_addr,
	input  logic                    branch,
	input  logic                    jalr,
	input  pc_t                     branoff,
	input  logic                    load_active,
	output logic                    rd_en,
	output word_addr_t              rd_addr,
	input  instr_t                  rd_data,
	output pc_t                     pc_id,
	output instr_t                  ins
);

	pc_t        pc;
	pc_t        next_pc;
	logic       pc_adv;
	logic       ins_valid;
	word_addr_t dbg_word;

	// Debug freezes the PC
	assign pc_adv = pc_en && !debug;

	// Next address, jalr wins over branch
	always_comb begin
		if (jalr)
			next_pc = branoff;
		else if (branch)
			next_pc = pc + branoff;
		else
			next_pc = pc + PC_STEP;
	end

	//////////////////////////////////////////////////
	// RAM read port
	//////////////////////////////////////////////////

	assign dbg_word = word_addr_t'(debug_addr);
	assign rd_en    = !load_active;
	// Drop the byte offset of the PC
	assign rd_addr  = debug ? dbg_word : pc[$bits(pc_t)-1:2];

	// Program counter, parked at 0 during a reload
	always_ff @(posedge bus) begin
		if (reset || load_active)
			pc <= PC_RESET;
		else if (pc_adv)
			pc <= next_pc;
	end

	// pc_id tracks the RAM latency so address and word stay paired
	always_ff @(posedge bus) begin
		if (reset) begin
			pc_id     <= PC_RESET;
			ins_valid <= 1'b0;
		end else begin
			pc_id     <= pc;
			ins_valid <= rd_en;
		end
	end

	// Zero until a read has completed
	assign ins = ins_valid ? rd_data : INSTR_ZERO;

	// Aligned offsets keep an aligned PC aligned
	assert property (@(posedge bus) disable iff (reset)
		(pc[1:0] == 2'b00 && branoff[1:0] == 2'b00) |=> (pc[1:0] == 2'b00))
	else
		$error("PC lost word alignment");

endmodule

`default_nettype wire

// File: fetch_top.sv
`timescale 1ns/1ns
`default_nettype none

module fetch_top import fetch_pkg::*, load_pkg::*; #(
	parameter int CLKS_PER_BIT = 4,
	parameter int IRAM_WORDS   = 1024
) (
	input  logic                    bus,
	input  logic                    reset,
	input  logic                    rx,
	input  logic                    prog,
	input  logic                    pc_en,
	input  logic                    debug,
	input  logic [DEBUG_ADDR_W-1:0] debug_addr,
	input  logic                    branch,
	input  logic                    jalr,
	input  pc_t                     branoff,
	output pc_t                     pc_id,
	output instr_t                  ins
);

	//////////////////////////////////////////////////
	// Interconnect
	//////////////////////////////////////////////////

	// UART to loader
	byte_t      rx_byte;
	logic       rx_valid;

	// Loader to RAM, Wishbone classic
	logic       wb_cyc;
	logic       wb_stb;
	logic       wb_we;
	word_addr_t wb_adr;
	instr_t     wb_dat_w;
	logic       wb_ack;
	logic       load_active;

	// Fetch read port
	logic       rd_en;
	word_addr_t rd_addr;
	instr_t     rd_data;

	uart_rx #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_uart_rx (
		.bus, .reset, .rx, .rx_byte, .rx_valid
	);

	prog_loader u_prog_loader (
		.bus, .reset, .prog, .rx_byte, .rx_valid,
		.wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w, .wb_ack, .load_active
	);

	iram_ctrl #(.IRAM_WORDS(IRAM_WORDS)) u_iram_ctrl (
		.bus, .reset, .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w, .wb_ack,
		.load_active, .rd_en, .rd_addr, .rd_data
	);

	fetch_stage u_fetch_stage (
		.bus, .reset, .pc_en, .debug, .debug_addr, .branch, .jalr, .branoff,
		.load_active, .rd_en, .rd_addr, .rd_data, .pc_id, .ins
	);

endmodule

`default_nettype wire

// File: tb_fetch_top.sv
`timescale 1ns/1ns
`default_nettype none

module tb_fetch_top import fetch_pkg::*, load_pkg::*; ();

	localparam int CLK_PERIOD   = 100;
	localparam int CLKS_PER_BIT = 4;
	localparam int IRAM_WORDS   = 1024;

	// Two loads of 16 and 8 words at four frames per word
	localparam int NUM_FRAMES   = (16 + 8) * BYTES_PER_WORD;
	// Reset, fetch runs and load overhead outside the frames
	localparam int FETCH_CYCLES = 120;
	localparam int TIMEOUT_CYCLES =
		(NUM_FRAMES * 10 * CLKS_PER_BIT + FETCH_CYCLES) * 3 / 2;

	logic                    bus = 1'b0;
	logic                    reset;
	logic                    rx;
	logic                    prog;
	logic                    pc_en;
	logic                    debug;
	logic [DEBUG_ADDR_W-1:0] debug_addr;
	logic                    branch;
	logic                    jalr;
	pc_t                     branoff;
	pc_t                     pc_id;
	instr_t                  ins;

	// Model memory written as words go out on the line
	instr_t model_mem [IRAM_WORDS];
	int     load_idx;
	integer seed;
	int     checks = 0;
	int     errors = 0;

	// Model state of the fetch path
	pc_t    m_pc;
	logic   m_la;

	fetch_top #(
		.CLKS_PER_BIT(CLKS_PER_BIT),
		.IRAM_WORDS  (IRAM_WORDS)
	) DUT (
		.bus       (bus),
		.reset     (reset),
		.rx        (rx),
		.prog      (prog),
		.pc_en     (pc_en),
		.debug     (debug),
		.debug_addr(debug_addr),
		.branch    (branch),
		.jalr      (jalr),
		.branoff   (branoff),
		.pc_id     (pc_id),
		.ins       (ins)
	);

	initial begin
		forever #(CLK_PERIOD / 2) bus = ~bus;
	end

	//////////////////////////////////////////////////
	// Reference model and checker
	//////////////////////////////////////////////////

	// Next PC by priority of jalr over branch over sequential
	function automatic pc_t ref_next_pc(input pc_t pc, input logic br, input logic jl,
		input pc_t off);
		if (jl)
			return off;
		else if (br)
			return pc + off;
		return pc + 12'd4;
	endfunction

	task automatic check_value(input string name, input logic [31:0] exp,
		input logic [31:0] act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("MISMATCH at %0t ns: %s expected %h actual %h", $time, name, exp, act);
		end
	endtask

	// Model one edge and compare on the following falling edge
	initial begin : compare_outputs
		pc_t        exp_pc_id;
		instr_t     exp_ins;
		word_addr_t rd_word;
		m_pc = '0;
		m_la = 1'b0;
		forever begin
			@(posedge bus);
			if (reset) begin
				exp_pc_id = '0;
				exp_ins   = '0;
				m_pc      = '0;
				m_la      = 1'b0;
			end else begin
				// Outputs show the PC and RAM word from before this edge
				exp_pc_id = m_pc;
				rd_word   = debug ? word_addr_t'(debug_addr) : m_pc[11:2];
				exp_ins   = m_la ? '0 : model_mem[rd_word];
				if (m_la)
					m_pc = '0;
				else if (pc_en && !debug)
					m_pc = ref_next_pc(m_pc, branch, jalr, branoff);
				// Writes are done before prog falls
				m_la = prog;
			end
			@(negedge bus);
			check_value("pc_id", exp_pc_id, pc_id);
			// Never-written RAM words hold no known value
			if (^exp_ins !== 1'bx)
				check_value("ins", exp_ins, ins);
		end
	end

	//////////////////////////////////////////////////
	// Stimulus tasks
	//////////////////////////////////////////////////

	// One 8N1 frame starting right after a falling edge
	task automatic send_frame(input byte_t data);
		int i;
		rx = 1'b0;
		repeat (CLKS_PER_BIT) @(negedge bus);
		// LSB first
		for (i = 0; i < UART_DATA_BITS; i++) begin
			rx = data[i];
			repeat (CLKS_PER_BIT) @(negedge bus);
		end
		rx = 1'b1;
		repeat (CLKS_PER_BIT) @(negedge bus);
	endtask

	task automatic push_word(input instr_t word);
		int b;
		model_mem[load_idx] = word;
		load_idx++;
		// Little-endian on the line
		for (b = 0; b < BYTES_PER_WORD; b++)
			send_frame(word[b*UART_DATA_BITS +: UART_DATA_BITS]);
	endtask

	// Load n random words from word 0
	task automatic reprogram(input int n);
		int     i;
		instr_t word;
		prog = 1'b1;
		repeat (2) @(negedge bus);
		load_idx = 0;
		for (i = 0; i < n; i++) begin
			word = $random(seed);
			push_word(word);
		end
		// Let the last write finish
		repeat (8) @(negedge bus);
		prog = 1'b0;
		repeat (2) @(negedge bus);
	endtask

	task automatic step_cycle(input logic en, input logic br, input logic jl, input pc_t off);
		pc_en   = en;
		branch  = br;
		jalr    = jl;
		branoff = off;
		@(negedge bus);
	endtask

	//////////////////////////////////////////////////
	// Test sequence
	//////////////////////////////////////////////////

	initial begin : stimulus
		int i;
		seed       = 32'hae93_c6e6;
		load_idx   = 0;
		reset      = 1'b1;
		rx         = 1'b1;
		prog       = 1'b0;
		pc_en      = 1'b0;
		debug      = 1'b0;
		debug_addr = '0;
		branch     = 1'b0;
		jalr       = 1'b0;
		branoff    = '0;
		repeat (5) @(negedge bus);
		reset = 1'b0;

		// Idle after reset with the PC parked at 0
		repeat (3) step_cycle(1'b0, 1'b0, 1'b0, '0);

		// Load and run straight through
		reprogram(16);
		repeat (16) step_cycle(1'b1, 1'b0, 1'b0, '0);

		// Jump home and branch forward and back
		step_cycle(1'b1, 1'b0, 1'b1, 12'd0);
		repeat (3) step_cycle(1'b1, 1'b1, 1'b0, 12'd8);
		step_cycle(1'b1, 1'b1, 1'b0, 12'hff8);
		step_cycle(1'b1, 1'b0, 1'b1, 12'd40);
		repeat (2) step_cycle(1'b1, 1'b0, 1'b0, '0);
		// Jalr wins when both are high
		step_cycle(1'b1, 1'b1, 1'b1, 12'd12);

		// Hold with pc_en low
		repeat (2) step_cycle(1'b0, 1'b0, 1'b0, '0);

		// Debug reads with the PC frozen despite a pending branch
		debug = 1'b1;
		for (i = 0; i < 16; i++) begin
			debug_addr = i[DEBUG_ADDR_W-1:0];
			step_cycle(1'b1, 1'b1, 1'b0, 12'd8);
		end
		debug = 1'b0;
		repeat (4) step_cycle(1'b1, 1'b0, 1'b0, '0);

		// Reload in the middle of a run
		reprogram(8);
		repeat (10) step_cycle(1'b1, 1'b0, 1'b0, '0);
		repeat (3) step_cycle(1'b0, 1'b0, 1'b0, '0);

		$display("Summary: %0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

	// Ends a hung run
	initial begin : watchdog
		#(TIMEOUT_CYCLES * CLK_PERIOD);
		$display("Timeout: test did not finish within %0d clock cycles", TIMEOUT_CYCLES);
		$display("=== FAIL ===");
		$finish;
	end

endmodule

`default_nettype wire

// File: fetch_top.f
fetch_pkg.sv
load_pkg.sv
uart_rx.sv
prog_loader.sv
iram_ctrl.sv
fetch_stage.sv
fetch_top.sv
tb_fetch_top.sv

// File: Bender.yml
package:
  name: fetch_top

sources:
  - fetch_pkg.sv
  - load_pkg.sv
  - uart_rx.sv
  - prog_loader.sv
  - iram_ctrl.sv
  - fetch_stage.sv
  - fetch_top.sv
  - target: simulation
    files:
      - tb_fetch_top.sv
